/* sim/lpf_testdata.txt */
// Columns: test id, input sample x[n], expected output y[n], 16-bit hex
// Tests 1 step, 2 impulse and negative full scale and alternating, 3 back-pressure, 4 input gaps
0001 1F40 03E8
0001 1F40 0753
0001 1F40 0A51
0001 1F40 0CEF
0001 1F40 0F39
0001 1F40 113A
0001 1F40 12FB
0001 1F40 1484
0002 7FFF 21F3
0002 0000 1DB5
0002 0000 19FE
0002 8000 06BE
0002 8000 F5E6
0002 8000 E729
0002 8000 DA44
0002 8000 CEFC
0002 4E20 DEE1
0002 B1E0 D941
0002 4E20 E7DD
0002 B1E0 E11D
0003 03E8 E576
0003 FFFF E8C7
0003 3039 F1B5
0003 EC78 F10D
0003 0007 F2EC
0004 7FFF 048E
0004 7FFF 13FC
0004 7FFF 217C

/* tb.f */
+incdir+logic
logic/lpf_pkg.sv
logic/mac_slice_if.sv
logic/mac_slice.sv
logic/lpf_sequencer.sv
logic/iir_lpf_top.sv
sim/tb_clock_gen.sv
sim/tb_checker.sv
sim/lpf_properties.sv
sim/tb_top.sv

/* run.sh */
#!/bin/sh
# Build the IIR low-pass filter testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim \
    || { echo "Build error"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator returned a failing status" >> sim.log
cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && { echo "Result: fail"; exit 1; }
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log || { echo "Result: no verdict in sim.log"; exit 1; }
echo "Result: pass"

/* sim/tb_top.sv */
//--------------------------------------------------------------------------
// Testbench of the first-order IIR low-pass filter
// Stimulus and expected samples come from sim/lpf_testdata.txt
// Inputs change 1 ns after the rising clock edge
// Test 3 stalls out_ready at random, test 4 adds long input gaps
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_top;

    localparam int PERIOD_NS = 20;
    localparam int MAX_VEC   = 64;
    localparam int MAX_WORDS = 3 * MAX_VEC; // Id, x[n] and y[n] per sample

    logic             reset;                // System clock
    logic             clk;                  // Asynchronous reset, active high
    logic             in_valid;
    logic             in_ready;
    lpf_pkg::sample_t in_data;
    logic             out_valid;
    logic             out_ready;
    lpf_pkg::sample_t out_data;

    logic [15:0]      vec_mem [0:MAX_WORDS-1];
    int               num_vec;
    logic             vec_loaded;
    logic             stall_mode;           // Random out_ready while set

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(10)) u_clk (
        .reset (reset),
        .clk   (clk)
    );

    iir_lpf_top dut (
        .reset     (reset),
        .clk       (clk),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    tb_checker u_check (
        .reset     (reset),
        .clk       (clk),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    // Offer one sample and hold it until the transfer edge
    task automatic send_sample(input lpf_pkg::sample_t value);
        in_valid = 1'b1;
        in_data  = value;
        while (!in_ready) begin
            @(posedge reset);
            #1;
        end
        @(posedge reset);                   // Transfer edge
        #1;
        in_valid = 1'b0;
    endtask

    initial begin : ready_drive
        forever begin
            @(posedge reset);
            #1;
            out_ready = stall_mode ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    end

    initial begin : stimulus
        int gap;
        int max_gap;
        int i;
        in_valid   = 1'b0;
        in_data    = '0;
        out_ready  = 1'b1;
        stall_mode = 1'b0;
        vec_loaded = 1'b0;
        void'($urandom(52284));
        // Unwritten words read as 16'hDExx, valid test ids stay below 16'h0100
        for (i = 0; i < MAX_WORDS; i++) begin
            vec_mem[i] = 16'hDE00 + 16'(i);
        end
        $readmemh("sim/lpf_testdata.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_mem[3 * num_vec] < 16'h0100) begin
            u_check.add_expected(int'(vec_mem[3 * num_vec]),
                                 lpf_pkg::sample_t'(vec_mem[3 * num_vec + 2]));
            num_vec++;
        end
        vec_loaded = 1'b1;

        @(negedge clk);                     // Reset released
        @(posedge reset);
        #1;
        for (i = 0; i < num_vec; i++) begin
            stall_mode = (vec_mem[3 * i] == 16'd3);
            max_gap    = (vec_mem[3 * i] == 16'd4) ? 12 : 3;
            gap        = $urandom_range(0, max_gap);
            repeat (gap) begin
                @(posedge reset);
                #1;
            end
            send_sample(lpf_pkg::sample_t'(vec_mem[3 * i + 1]));
        end

        wait (u_check.checked_count == num_vec);
        stall_mode = 1'b0;
        repeat (20) @(posedge reset);       // Catch extra outputs
        u_check.print_summary();
        if (u_check.error_count == 0 && u_check.checked_count == num_vec) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        wait (vec_loaded);
        repeat (num_vec * 20 + 200) @(posedge reset);
        $display("Timeout: %0d of %0d outputs arrived within %0d clock periods",
                 u_check.checked_count, num_vec, num_vec * 20 + 200);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/lpf_properties.sv */
//--------------------------------------------------------------------------
// Handshake and reset assertions of the filter front end
// Bound to every lpf_sequencer instance, clocked on the net named reset
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module lpf_properties (
    input logic             reset,          // System clock
    input logic             clk,            // Asynchronous reset, active high
    input logic             in_valid,
    input logic             in_ready,
    input lpf_pkg::sample_t in_data,
    input logic             out_valid,
    input logic             out_ready,
    input lpf_pkg::sample_t out_data
);

    // Offered output holds until downstream takes it
    out_hold: assert property (@(posedge reset) disable iff (clk)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_valid or out_data changed before the output transfer");

    // Offered input holds until the filter takes it
    in_hold: assert property (@(posedge reset) disable iff (clk)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else $error("in_valid or in_data changed before the input transfer");

    // One sample in flight
    no_overlap: assert property (@(posedge reset) disable iff (clk)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid are high together");

    reset_quiet: assert property (@(posedge reset) clk |-> !out_valid)
        else $error("out_valid is high during reset");

endmodule

bind lpf_sequencer lpf_properties u_props (
    .reset     (reset),
    .clk       (clk),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

`default_nettype wire

/* sim/tb_checker.sv */
//--------------------------------------------------------------------------
// Output checker of the IIR low-pass filter testbench
// Expected samples arrive in file order through add_expected
// Samples at the rising clock edge, so it sees pre-edge DUT values
// Also checks the reset state, the 6-cycle latency and output hold
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_checker (
    input logic             reset,          // System clock
    input logic             clk,            // Asynchronous reset, active high
    input logic             in_valid,       // DUT input handshake
    input logic             in_ready,
    input logic             out_valid,      // DUT output handshake
    input logic             out_ready,
    input lpf_pkg::sample_t out_data        // Filtered sample
);

    localparam int LATENCY = 6;             // Input transfer to out_valid

    int               exp_id_q [$];         // Test id of each expected sample
    lpf_pkg::sample_t exp_val_q [$];        // Expected y[n] in file order

    int               error_count   = 0;
    int               checked_count = 0;    // Output transfers compared
    int               test_count    = 0;
    int               test_errors   = 0;
    int               test_samples  = 0;
    int               cycle         = 0;    // Edge counter
    int               accept_cycle  = 0;    // Edge of the last input transfer
    logic             out_valid_d   = 1'b0;
    logic             hold_pending  = 1'b0; // Output offered but not taken
    logic             reset_checked = 1'b0;
    lpf_pkg::sample_t held_data     = '0;

    task automatic add_expected(input int id, input lpf_pkg::sample_t value);
        exp_id_q.push_back(id);
        exp_val_q.push_back(value);
    endtask

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d samples, %0d errors, %s", name, test_samples, test_errors,
                 (test_errors == 0) ? "pass" : "fail");
        test_count++;
        test_samples = 0;
        test_errors  = 0;
    endtask

    task automatic print_summary();
        $display("Summary: %0d tests, %0d outputs checked, %0d errors",
                 test_count, checked_count, error_count);
    endtask

    //----------------------------------------------------------------------
    // Compare one output transfer
    //----------------------------------------------------------------------
    task automatic compare_transfer();
        int               id;
        lpf_pkg::sample_t expected;
        if (exp_id_q.size() == 0) begin
            $display("Unexpected output %0d at %0t ns, no expected sample is left",
                     out_data, $time);
            note_error();
        end else begin
            id       = exp_id_q.pop_front();
            expected = exp_val_q.pop_front();
            checked_count++;
            test_samples++;
            if (out_data !== expected) begin
                $display("ERROR %0t ns out_data expected %0d got %0d", $time, expected, out_data);
                note_error();
            end
            if (exp_id_q.size() == 0 || exp_id_q[0] != id) begin
                end_test($sformatf("test %0d", id));    // Last sample of this test
            end
        end
    endtask

    always @(posedge reset) begin : watch
        int latency;
        cycle++;
        if (clk) begin
            out_valid_d  = 1'b0;
            hold_pending = 1'b0;
        end else begin
            // First edge after reset release
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (in_ready !== 1'b1) begin
                    $display("ERROR %0t ns in_ready expected 1 got %b", $time, in_ready);
                    note_error();
                end
                if (out_valid !== 1'b0) begin
                    $display("ERROR %0t ns out_valid expected 0 got %b", $time, out_valid);
                    note_error();
                end
                end_test("test 0 reset state");
            end

            if (in_valid && in_ready) begin
                accept_cycle = cycle;
            end

            // out_valid went high after the previous edge
            if (out_valid && !out_valid_d) begin
                latency = cycle - 1 - accept_cycle;
                if (latency != LATENCY) begin
                    $display({"Latency error at %0t ns: out_valid rose %0d cycles",
                              " after the input transfer instead of %0d"},
                             $time, latency, LATENCY);
                    note_error();
                end
            end

            if (hold_pending) begin
                if (!out_valid) begin
                    $display("out_valid dropped at %0t ns before the output was taken", $time);
                    note_error();
                end else if (out_data !== held_data) begin
                    $display("ERROR %0t ns out_data expected %0d got %0d",
                             $time, held_data, out_data);
                    note_error();
                end
            end

            if (out_valid && out_ready) begin
                compare_transfer();
                hold_pending = 1'b0;
            end else if (out_valid) begin
                hold_pending = 1'b1;        // Stalled so the value must hold
                held_data    = out_data;
            end
            out_valid_d = out_valid;
        end
    end

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
//--------------------------------------------------------------------------
// Clock and reset source of the IIR low-pass filter testbench
// The net named reset is the clock and clk is the active high reset
// Reset is released 1 ns after the last reset edge
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,        // Clock period
    parameter int RESET_CYCLES = 10         // Edges with reset held
) (
    output logic reset,                     // System clock
    output logic clk                        // Asynchronous reset, active high
);

    initial begin
        reset = 1'b0;
        forever #(PERIOD_NS / 2) reset = ~reset;
    end

    initial begin
        clk = 1'b1;                         // Reset from time zero
        repeat (RESET_CYCLES) @(posedge reset);
        #1 clk = 1'b0;
    end

endmodule

`default_nettype wire

/* logic/iir_lpf_top.sv */
//--------------------------------------------------------------------------
// First-order IIR low-pass filter with valid/ready sample ports
// Six cycles from input transfer to out_valid, one sample at a time
// Coefficients are fixed at build time
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module iir_lpf_top (
    input  logic             reset,         // System clock
    input  logic             clk,           // Asynchronous reset, active high
    input  logic             in_valid,      // Input sample offered
    output logic             in_ready,      // Filter can take a sample
    input  lpf_pkg::sample_t in_data,       // Input sample
    output logic             out_valid,     // Filtered sample available
    input  logic             out_ready,     // Downstream ready
    output lpf_pkg::sample_t out_data       // Filtered sample
);

    // Operand and result bundle of the MAC slice
    mac_slice_if mac_bus ();

    // Handshake, FSM and output rounding
    lpf_sequencer u_seq (
        .reset     (reset),
        .clk       (clk),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .mac       (mac_bus.master)
    );

    // Pipelined multiply-accumulate
    mac_slice u_slice (
        .reset (reset),
        .clk   (clk),
        .mac   (mac_bus.slice)
    );

endmodule

`default_nettype wire

/* logic/lpf_sequencer.sv */
//--------------------------------------------------------------------------
// Front end of the IIR low-pass filter, y[n] = A*x[n] + B*y[n-1]
// One sample in flight, in_ready is high only in IDLE
// Accept at edge 0, out_valid after edge 6 with out_ready high
// Result is rounded half up, shifted by FRAC_BITS and saturated
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "lpf_settings.svh"

module lpf_sequencer (
    input  logic             reset,         // System clock
    input  logic             clk,           // Asynchronous reset, active high
    input  logic             in_valid,      // Input sample offered
    output logic             in_ready,      // Ready for a new sample
    input  lpf_pkg::sample_t in_data,       // Input sample x[n]
    output logic             out_valid,     // Output sample available
    input  logic             out_ready,     // Downstream takes the sample
    output lpf_pkg::sample_t out_data,      // Output sample y[n]
    mac_slice_if.master      mac            // Operations to the slice
);

    localparam logic [1:0] WAIT_LAST = 2'(`LPF_WAIT_CYCLES - 1);

    // Half an LSB of the result and the sample range in P units
    localparam lpf_pkg::acc_t ROUND_HALF = lpf_pkg::acc_t'(1) <<< (`LPF_FRAC_BITS - 1);
    localparam lpf_pkg::acc_t SAT_MAX    = (lpf_pkg::acc_t'(1) <<< (`LPF_SAMPLE_W - 1)) - 1;
    localparam lpf_pkg::acc_t SAT_MIN    = -SAT_MAX - 1;

    //----------------------------------------------------------------------
    // State
    //----------------------------------------------------------------------
    lpf_pkg::seq_state_t state;             // FSM state
    logic [1:0]          wait_cnt;          // Cycles spent in WAIT_P
    lpf_pkg::sample_t    x_reg;             // Accepted x[n]
    lpf_pkg::sample_t    y_reg;             // Output register, also y[n-1]

    logic                in_fire;           // Input transfer this edge
    logic                out_fire;          // Output transfer this edge
    logic                p_ready;           // P holds the final sum

    lpf_pkg::acc_t       p_round;           // P plus half an LSB
    lpf_pkg::acc_t       p_shift;           // Rounded P in sample units
    lpf_pkg::sample_t    y_sat;             // Saturated result

    assign in_ready  = (state == lpf_pkg::IDLE);
    assign out_valid = (state == lpf_pkg::OUTPUT);
    assign out_data  = y_reg;

    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;
    assign p_ready  = (state == lpf_pkg::WAIT_P) && (wait_cnt == WAIT_LAST);

    //----------------------------------------------------------------------
    // Round, shift and saturate the accumulator
    //----------------------------------------------------------------------
    always_comb begin
        p_round = mac.p_out + ROUND_HALF;
        p_shift = p_round >>> `LPF_FRAC_BITS;   // Arithmetic shift keeps the sign
        if (p_shift > SAT_MAX) begin
            y_sat = lpf_pkg::sample_t'(SAT_MAX);    // Clip at positive full scale
        end else if (p_shift < SAT_MIN) begin
            y_sat = lpf_pkg::sample_t'(SAT_MIN);    // Clip at negative full scale
        end else begin
            y_sat = lpf_pkg::sample_t'(p_shift);
        end
    end

    //----------------------------------------------------------------------
    // FSM, wait counter, op_en and the result register
    //----------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state     <= lpf_pkg::IDLE;
            wait_cnt  <= '0;
            mac.op_en <= 1'b0;
            y_reg     <= '0;                // y[n-1] starts at zero
        end else begin
            // Slice sees an operation on the cycle after each ISSUE state
            mac.op_en <= (state == lpf_pkg::ISSUE_X) || (state == lpf_pkg::ISSUE_Y);

            case (state)
                lpf_pkg::IDLE: begin
                    if (in_fire) begin
                        state <= lpf_pkg::ISSUE_X;
                    end
                end
                lpf_pkg::ISSUE_X: begin
                    state <= lpf_pkg::ISSUE_Y;    // x operation leaves at edge 1
                end
                lpf_pkg::ISSUE_Y: begin
                    state    <= lpf_pkg::WAIT_P;  // y operation leaves at edge 2
                    wait_cnt <= '0;
                end
                lpf_pkg::WAIT_P: begin
                    wait_cnt <= wait_cnt + 2'd1;
                    if (p_ready) begin
                        state <= lpf_pkg::OUTPUT; // Result registered at edge 6
                        y_reg <= y_sat;
                    end
                end
                lpf_pkg::OUTPUT: begin
                    if (out_fire) begin
                        state <= lpf_pkg::IDLE;   // Held until downstream takes it
                    end
                end
                default: begin
                    state <= lpf_pkg::IDLE;
                end
            endcase
        end
    end

    //----------------------------------------------------------------------
    // Sample capture and operand registers
    //----------------------------------------------------------------------
    always_ff @(posedge reset) begin
        if (in_fire) begin
            x_reg <= in_data;               // in_data may change after transfer
        end
        if (state == lpf_pkg::ISSUE_X) begin
            mac.a_op <= `LPF_COEF_A;
            mac.b_op <= lpf_pkg::coef_t'(x_reg);    // Sign extended x[n]
            mac.op   <= lpf_pkg::MAC_LOAD;
        end else if (state == lpf_pkg::ISSUE_Y) begin
            mac.a_op <= `LPF_COEF_B;
            mac.b_op <= lpf_pkg::coef_t'(y_reg);    // Sign extended y[n-1]
            mac.op   <= lpf_pkg::MAC_ACC;
        end
    end

endmodule

`default_nettype wire

/* logic/mac_slice.sv */
//--------------------------------------------------------------------------
// Behavioral multiply-accumulate slice, vendor neutral
// Pipeline is A1/B1, M, P with a doubly registered opmode
// Operands presented after edge k give M after k+2 and P after k+3
// No cascade, pre-adder or carry logic
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module mac_slice (
    input  logic          reset,            // System clock
    input  logic          clk,              // Asynchronous reset, active high
    mac_slice_if.slice    mac               // Operands in, M and P out
);

    //----------------------------------------------------------------------
    // Pipeline registers
    //----------------------------------------------------------------------
    lpf_pkg::coef_t   a1_reg;               // Operand A stage
    lpf_pkg::coef_t   b1_reg;               // Operand B stage
    lpf_pkg::prod_t   m_reg;                // Product stage
    lpf_pkg::acc_t    p_reg;                // Accumulator stage

    lpf_pkg::mac_op_t op_d1;                // Opmode beside A1/B1
    lpf_pkg::mac_op_t op_d2;                // Opmode beside M
    logic             en_d1;                // Valid beside A1/B1
    logic             en_d2;                // Valid beside M

    lpf_pkg::acc_t    m_ext;                // Product widened for the adder

    // Sign extend M to the accumulator width
    assign m_ext = lpf_pkg::acc_t'(m_reg);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            a1_reg <= '0;
            b1_reg <= '0;
            op_d1  <= lpf_pkg::MAC_LOAD;
            en_d1  <= 1'b0;
            m_reg  <= '0;
            op_d2  <= lpf_pkg::MAC_LOAD;
            en_d2  <= 1'b0;
            p_reg  <= '0;
        end else begin
            // Input stage takes the bus every cycle like a CE tied high
            a1_reg <= mac.a_op;
            b1_reg <= mac.b_op;
            op_d1  <= mac.op;
            en_d1  <= mac.op_en;

            // Signed 18x18 multiply into M
            m_reg  <= a1_reg * b1_reg;
            op_d2  <= op_d1;                // Second opmode delay lines up with M
            en_d2  <= en_d1;

            // Post adder, P holds when no operation reaches this stage
            if (en_d2) begin
                if (op_d2 == lpf_pkg::MAC_ACC) begin
                    p_reg <= p_reg + m_ext; // P = P + M
                end else begin
                    p_reg <= m_ext;         // P = M
                end
            end
        end
    end

    //----------------------------------------------------------------------
    // Outputs
    //----------------------------------------------------------------------
    assign mac.m_out = m_reg;
    assign mac.p_out = p_reg;

endmodule

`default_nettype wire

/* logic/mac_slice_if.sv */
//--------------------------------------------------------------------------
// Operand and result bundle between the sequencer and the MAC slice
// No handshake, one operation is taken on every clock with op_en high
// Result timing is fixed by the slice pipeline depth
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

interface mac_slice_if;

    // Operation request
    lpf_pkg::coef_t   a_op;                 // Multiplier operand A
    lpf_pkg::coef_t   b_op;                 // Multiplier operand B
    lpf_pkg::mac_op_t op;                   // Load or accumulate
    logic             op_en;                // Operation valid this cycle

    // Slice results
    lpf_pkg::prod_t   m_out;                // Registered product
    lpf_pkg::acc_t    p_out;                // Registered accumulator

    // Sequencer side
    modport master (
        output a_op,
        output b_op,
        output op,
        output op_en,
        input  m_out,
        input  p_out
    );

    // Slice side
    modport slice (
        input  a_op,
        input  b_op,
        input  op,
        input  op_en,
        output m_out,
        output p_out
    );

endinterface

`default_nettype wire

/* logic/lpf_pkg.sv */
//--------------------------------------------------------------------------
// Shared types of the IIR low-pass filter
// Widths come from the settings header
//--------------------------------------------------------------------------

`default_nettype none

`include "lpf_settings.svh"

package lpf_pkg;

    // Vectors with a fixed meaning
    typedef logic signed [`LPF_SAMPLE_W-1:0] sample_t;   // Filter sample
    typedef logic signed [`LPF_COEF_W-1:0]   coef_t;     // Multiplier operand
    typedef logic signed [`LPF_PROD_W-1:0]   prod_t;     // M product
    typedef logic signed [`LPF_ACC_W-1:0]    acc_t;      // P accumulator

    // Slice opmode
    typedef logic [0:0] mac_op_t;
    localparam mac_op_t MAC_LOAD = 1'b0;                  // P = M
    localparam mac_op_t MAC_ACC  = 1'b1;                  // P = P + M

    // Sequencer FSM
    typedef enum logic [2:0] {
        IDLE,                                             // Waiting for a sample
        ISSUE_X,                                          // Drive COEF_A * x[n]
        ISSUE_Y,                                          // Drive COEF_B * y[n-1]
        WAIT_P,                                           // Slice pipeline drains
        OUTPUT                                            // Result waits for out_ready
    } seq_state_t;

endpackage

`default_nettype wire

/* logic/lpf_settings.svh */
//--------------------------------------------------------------------------
// Widths and fixed coefficients of the first-order IIR low-pass filter
// Coefficients are Q1.17 and must fit the signed coefficient width
// COEF_A + COEF_B equals 1.0 so the DC gain is unity
//--------------------------------------------------------------------------

`ifndef LPF_SETTINGS_SVH
`define LPF_SETTINGS_SVH

// Data path widths
`define LPF_SAMPLE_W    16              // Filter input and output sample
`define LPF_COEF_W      18              // Multiplier operand A and B
`define LPF_PROD_W      36              // Product in the M register
`define LPF_ACC_W       48              // Accumulator in the P register

// Fixed point scaling
`define LPF_FRAC_BITS   17              // Fraction bits of the coefficients

// Filter coefficients in Q1.17
`define LPF_COEF_A      18'sd16384      // About 0.125, weight of x[n]
`define LPF_COEF_B      18'sd114688     // About 0.875, weight of y[n-1]

// Cycles spent in WAIT_P before P holds the final sum
`define LPF_WAIT_CYCLES 4

`endif
